//--- Makefile
VERILATOR ?= verilator
TOP       ?= port_wr_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- src/port_wr_frontend.sv
`timescale 1ns/1ps

module port_wr_frontend import switch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_sop,   // Pulse one cycle ahead of the header.
    input  logic       wr_vld,
    input  logic       wr_eop,   // Pulse after the last halfword.
    input  pkt_word_u  wr_data,
    input  grant_t     grant,
    output logic       pause,
    output match_req_t req,
    output xfer_t      xfer
);

    typedef enum logic [1:0] {WR_IDLE, WR_HDR, WR_DATA, WR_DONE} wr_state_t;
    typedef enum logic [1:0] {X_IDLE, X_SEND, X_STALL} xfer_state_t;

    localparam int PAUSE_LVL = FIFO_DEPTH - 3;  // Leaves room for words in flight.

    wr_state_t          wr_state;
    xfer_state_t        xfer_state;

    logic [HW_W-1:0]    buffer [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] xfer_ptr;
    logic [FIFO_AW-1:0] xfer_ptr_nxt;
    logic [FIFO_AW-1:0] fifo_cnt;
    logic [FIFO_AW-1:0] hdr_ptr;    // Slot holding the header of the packet in match.
    logic [FIFO_AW-1:0] new_end;
    logic [FIFO_AW-1:0] pend_end;   // End slot of a granted packet not yet started.
    logic [FIFO_AW-1:0] cur_end;    // End slot of the packet being sent.
    logic [8:0]         wr_cnt;
    logic               wr_accept;
    logic               grant_pend;
    logic               xfer_start;
    logic               xfer_last;
    logic               xfer_vld_q;
    logic [HW_W-1:0]    xfer_data_q;
    logic               xfer_eop_q;

    // Words are taken only inside a packet.
    assign wr_accept    = wr_vld && (wr_state == WR_HDR || wr_state == WR_DATA);
    assign fifo_cnt     = wr_ptr - xfer_ptr;
    assign xfer_ptr_nxt = xfer_ptr + 1'b1;
    assign new_end      = hdr_ptr + req.length[FIFO_AW-1:0];  // Packets sit back to back.
    assign xfer_start   = (xfer_state == X_IDLE) && (grant.suc || grant_pend);
    assign xfer_last    = (xfer_state == X_SEND) && (xfer_ptr_nxt == cur_end);

    // Write FSM.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_sop) begin
                        wr_state <= WR_HDR;
                    end
                end
                WR_HDR: begin
                    if (wr_vld) begin
                        wr_state <= (wr_data.hdr.length > 9'd1) ? WR_DATA : WR_DONE;
                    end
                end
                WR_DATA: begin
                    if (wr_vld && (wr_cnt + 9'd1 == req.length)) begin
                        wr_state <= WR_DONE;  // Last halfword in.
                    end
                end
                WR_DONE: begin
                    if (wr_sop) begin
                        wr_state <= WR_HDR;   // Back to back packet.
                    end else if (wr_eop) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            buffer[wr_ptr] <= wr_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            hdr_ptr <= '0;
            wr_cnt  <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_state == WR_HDR) begin
                hdr_ptr <= wr_ptr;   // Packet starts here.
                wr_cnt  <= 9'd1;
            end else begin
                wr_cnt <= wr_cnt + 9'd1;
            end
        end
    end

    // Request is raised by the header and dropped by the grant.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= '0;
        end else if (wr_accept && wr_state == WR_HDR) begin
            req.enable <= 1'b1;
            req.dest   <= wr_data.hdr.dest;
            req.length <= wr_data.hdr.length;
        end else if (grant.suc) begin
            req.enable <= 1'b0;
        end
    end

    // Keep a grant that lands while the previous packet still drains.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_pend <= 1'b0;
        end else if (grant.suc && xfer_state != X_IDLE) begin
            grant_pend <= 1'b1;
        end else if (xfer_start) begin
            grant_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant.suc) begin
            pend_end <= new_end;
        end
        if (xfer_start) begin
            cur_end <= grant.suc ? new_end : pend_end;
        end
    end

    // Transfer FSM.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xfer_state <= X_IDLE;
        end else begin
            case (xfer_state)
                X_IDLE: begin
                    if (xfer_start) begin
                        xfer_state <= X_SEND;
                    end
                end
                X_SEND: begin
                    if (xfer_last) begin
                        xfer_state <= X_IDLE;
                    end else if (xfer_ptr_nxt == wr_ptr) begin
                        xfer_state <= X_STALL;  // Caught up with the writer.
                    end
                end
                X_STALL: begin
                    if (xfer_ptr != wr_ptr) begin
                        xfer_state <= X_SEND;
                    end
                end
                default: xfer_state <= X_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xfer_ptr   <= '0;
            xfer_vld_q <= 1'b0;
            xfer_eop_q <= 1'b0;
        end else begin
            xfer_vld_q <= (xfer_state == X_SEND);
            xfer_eop_q <= xfer_last;
            if (xfer_state == X_SEND) begin
                xfer_ptr <= xfer_ptr_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        xfer_data_q <= buffer[xfer_ptr];
    end

    assign xfer = '{vld: xfer_vld_q, data: xfer_data_q, eop: xfer_eop_q};

    // Hold the source near full or while the header waits for a bank.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause <= 1'b0;
        end else begin
            pause <= (fifo_cnt >= FIFO_AW'(PAUSE_LVL)) || (req.enable && !grant.suc);
        end
    end

endmodule

//--- src/port_wr_top.sv
`timescale 1ns/1ps

module port_wr_top import switch_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_sop,
    input  logic                          wr_vld,
    input  logic                          wr_eop,
    input  pkt_word_u                     wr_data,
    input  free_t                         free,
    input  logic [1:0]                    rd_bank,
    input  logic [$clog2(BANK_DEPTH)-1:0] rd_addr,
    output logic                          pause,
    output logic                          desc_vld,
    output desc_t                         desc,
    output logic [HW_W-1:0]               rd_data
);

    match_req_t                    req;
    grant_t                        grant;     // Shared by frontend and writer.
    xfer_t                         xfer;
    logic                          bank_wr_en;
    logic [1:0]                    bank_wr_bank;
    logic [$clog2(BANK_DEPTH)-1:0] bank_wr_addr;
    logic [HW_W-1:0]               bank_wr_data;

    port_wr_frontend u_frontend (
        .clk, .rst_n, .wr_sop, .wr_vld, .wr_eop, .wr_data,
        .grant, .pause, .req, .xfer
    );

    sram_matcher #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) u_matcher (
        .clk, .rst_n, .req, .free, .grant
    );

    sram_bank_writer #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) u_writer (
        .clk, .rst_n, .grant, .xfer,
        .wr_en(bank_wr_en), .wr_bank(bank_wr_bank),
        .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
        .desc_vld, .desc
    );

    sram_bank #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) u_bank (
        .clk,
        .wr_en(bank_wr_en), .wr_bank(bank_wr_bank),
        .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
        .rd_bank, .rd_addr, .rd_data
    );

endmodule

//--- src/sram_bank.sv
`timescale 1ns/1ps

module sram_bank import switch_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [1:0]                    wr_bank,
    input  logic [$clog2(BANK_DEPTH)-1:0] wr_addr,
    input  logic [HW_W-1:0]               wr_data,
    input  logic [1:0]                    rd_bank,
    input  logic [$clog2(BANK_DEPTH)-1:0] rd_addr,
    output logic [HW_W-1:0]               rd_data
);

    localparam int MEM_DEPTH = NUM_BANKS * BANK_DEPTH;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    logic [HW_W-1:0]   mem [MEM_DEPTH];  // Banks laid out one after another.
    logic [MEM_AW-1:0] wr_idx;
    logic [MEM_AW-1:0] rd_idx;

    assign wr_idx = MEM_AW'(wr_bank) * MEM_AW'(BANK_DEPTH) + MEM_AW'(wr_addr);
    assign rd_idx = MEM_AW'(rd_bank) * MEM_AW'(BANK_DEPTH) + MEM_AW'(rd_addr);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- src/sram_bank_writer.sv
`timescale 1ns/1ps

module sram_bank_writer import switch_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  grant_t                        grant,
    input  xfer_t                         xfer,
    output logic                          wr_en,
    output logic [1:0]                    wr_bank,
    output logic [$clog2(BANK_DEPTH)-1:0] wr_addr,
    output logic [HW_W-1:0]               wr_data,
    output logic                          desc_vld,
    output desc_t                         desc
);

    localparam int BANK_AW = $clog2(BANK_DEPTH);

    logic [1:0]         gq [2];        // Grants not yet streamed.
    logic               gq_rd;
    logic               gq_wr;
    logic [1:0]         gq_cnt;
    logic               pop;
    logic [1:0]         cur_bank;
    logic [BANK_AW-1:0] wp [NUM_BANKS];
    logic [BANK_AW-1:0] wp_cur;
    logic [BANK_AW-1:0] wp_inc;
    logic [BANK_AW-1:0] start_q;
    logic [8:0]         len_q;
    logic [3:0]         dest_q;
    logic [8:0]         hw_cnt;
    logic               first;
    pkt_word_u          word;

    assign cur_bank = gq[gq_rd];
    assign wp_cur   = wp[cur_bank];
    assign wp_inc   = (wp_cur == BANK_AW'(BANK_DEPTH - 1)) ? '0 : wp_cur + 1'b1;  // Wraps.
    assign first    = (hw_cnt == '0);
    assign word.raw = xfer.data;
    assign pop      = xfer.vld && xfer.eop && (gq_cnt != '0);

    // Bank write happens in the arrival cycle.
    assign wr_en   = xfer.vld;
    assign wr_bank = cur_bank;
    assign wr_addr = wp_cur;
    assign wr_data = xfer.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gq_rd  <= 1'b0;
            gq_wr  <= 1'b0;
            gq_cnt <= '0;
        end else begin
            if (grant.suc) begin
                gq_wr <= ~gq_wr;
            end
            if (pop) begin
                gq_rd <= ~gq_rd;
            end
            gq_cnt <= gq_cnt + 2'(grant.suc) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (grant.suc) begin
            gq[gq_wr] <= grant.bank;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                wp[b] <= '0;
            end
            hw_cnt <= '0;
        end else if (xfer.vld) begin
            wp[cur_bank] <= wp_inc;
            hw_cnt       <= xfer.eop ? 9'd0 : hw_cnt + 9'd1;
        end
    end

    // Header fields from the first halfword.
    always_ff @(posedge clk) begin
        if (xfer.vld && first) begin
            start_q <= wp_cur;
            len_q   <= word.hdr.length;
            dest_q  <= word.hdr.dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_vld <= 1'b0;
        end else begin
            desc_vld <= xfer.vld && xfer.eop;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer.vld && xfer.eop) begin
            desc.bank   <= cur_bank;
            desc.start  <= first ? wp_cur : start_q;  // Single halfword packet.
            desc.length <= first ? word.hdr.length : len_q;
            desc.dest   <= first ? word.hdr.dest : dest_q;
        end
    end

endmodule

//--- src/sram_matcher.sv
`timescale 1ns/1ps

module sram_matcher import switch_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  match_req_t req,
    input  free_t      free,
    output grant_t     grant
);

    typedef enum logic {M_IDLE, M_PICK} m_state_t;

    localparam int CNT_W = $clog2(BANK_DEPTH + 1);  // Counts up to a whole bank.

    m_state_t         state;
    logic [CNT_W-1:0] free_cnt [NUM_BANKS];
    logic [CNT_W-1:0] add_len  [NUM_BANKS];
    logic [CNT_W-1:0] sub_len  [NUM_BANKS];
    logic             fit;
    logic [1:0]       pick;
    logic             take;

    // Lowest numbered bank with room wins.
    always_comb begin
        fit  = 1'b0;
        pick = '0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (free_cnt[b] >= req.length) begin
                fit  = 1'b1;
                pick = 2'(b);
            end
        end
    end

    assign take = (state == M_PICK) && req.enable && fit;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_len[b] = (free.vld && free.bank == 2'(b)) ? CNT_W'(free.length) : '0;
            sub_len[b] = (take && pick == 2'(b)) ? CNT_W'(req.length) : '0;  // Reservation.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                free_cnt[b] <= CNT_W'(BANK_DEPTH);
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                free_cnt[b] <= free_cnt[b] + add_len[b] - sub_len[b];
            end
        end
    end

    // One idle cycle after enable, then retry every cycle until a bank fits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE: begin
                    if (req.enable && !grant.suc) begin  // Not the request just served.
                        state <= M_PICK;
                    end
                end
                M_PICK: begin
                    if (!req.enable || fit) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= '{suc: take, bank: pick};
        end
    end

endmodule

//--- src/switch_pkg.sv
package switch_pkg;

    // Frontend FIFO geometry.
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;

    localparam int HW_W = 16;  // One halfword on the ingress bus.

    // Header halfword, MSB first.
    typedef struct packed {
        logic [8:0] length;  // Halfwords in the packet, header included.
        logic [2:0] prio;    // Carried along, not scheduled on.
        logic [3:0] dest;
    } pkt_hdr_t;

    // The first halfword is both payload and header.
    typedef union packed {
        logic [HW_W-1:0] raw;
        pkt_hdr_t        hdr;
    } pkt_word_u;

    // Frontend to bank writer stream.
    typedef struct packed {
        logic            vld;
        logic [HW_W-1:0] data;
        logic            eop;  // Set with the last halfword.
    } xfer_t;

    typedef struct packed {
        logic       enable;  // Held until the grant pulse.
        logic [3:0] dest;
        logic [8:0] length;
    } match_req_t;

    typedef struct packed {
        logic       suc;   // One cycle pulse.
        logic [1:0] bank;
    } grant_t;

    // Where a stored packet lives.
    typedef struct packed {
        logic [1:0] bank;
        logic [7:0] start;   // First bank address.
        logic [8:0] length;
        logic [3:0] dest;
    } desc_t;

    // Space handed back by the read side.
    typedef struct packed {
        logic       vld;
        logic [1:0] bank;
        logic [8:0] length;
    } free_t;

endpackage

//--- verification/port_wr_asserts.sv
`timescale 1ns/1ps

module port_wr_asserts import switch_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic [1:0]         xfer_state,
    input xfer_t              xfer,
    input logic               wr_accept,
    input logic [FIFO_AW-1:0] fifo_cnt,
    input grant_t             grant       // Matcher output as the frontend sees it.
);

    localparam logic [1:0] XFER_IDLE = 2'd0;  // X_IDLE encoding.

    // Idle stream, except the eop word still leaving the output register.
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer_state == XFER_IDLE && xfer.vld) |-> xfer.eop)
        else $error("xfer.vld high in the idle transfer state");

    suc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        grant.suc |=> !grant.suc)
        else $error("grant.suc held for more than one cycle");

    // 63 entries is the most the pointers can tell apart.
    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_accept |-> fifo_cnt < FIFO_AW'(FIFO_DEPTH - 1))
        else $error("write into a full packet FIFO");

endmodule

bind port_wr_frontend port_wr_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .xfer_state(xfer_state),
    .xfer      (xfer),
    .wr_accept (wr_accept),
    .fifo_cnt  (fifo_cnt),
    .grant     (grant)
);

//--- verification/port_wr_tb.sv
`timescale 1ns/1ps

module port_wr_tb import switch_pkg::*; ();

    localparam int NUM_PKTS    = 60;
    localparam int MAX_LEN     = 40;
    localparam int NUM_BANKS   = 4;    // DUT defaults.
    localparam int BANK_DEPTH  = 256;
    localparam int CYC_PER_PKT = 200;  // Watchdog budget per packet.
    localparam int E_DESC  = 0;        // Error classes.
    localparam int E_PLACE = 1;
    localparam int E_DATA  = 2;
    localparam int E_CTRL  = 3;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            wr_sop;
    logic            wr_vld;
    logic            wr_eop;
    pkt_word_u       wr_data;
    free_t           free;
    logic [1:0]      rd_bank;
    logic [7:0]      rd_addr;
    logic            pause;
    logic            desc_vld;
    desc_t           desc;
    logic [HW_W-1:0] rd_data;

    integer          seed = 32'hdcc4_4d85;
    logic [HW_W-1:0] pkt_data [NUM_PKTS][MAX_LEN];  // Word 0 is the header.
    logic            word_gap [NUM_PKTS][MAX_LEN];  // Idle cycle before the word.
    int              pkt_len   [NUM_PKTS];
    int              pkt_gap   [NUM_PKTS];
    int              free_dly  [NUM_PKTS];
    int              exp_bank  [NUM_PKTS];
    int              exp_start [NUM_PKTS];
    int              model_free [NUM_BANKS];
    int              model_wp   [NUM_BANKS];
    int              grant_idx = 0;
    int              free_wait = 0;
    int              n_checked = 0;
    int              err_cnt [4] = '{default: 0};
    desc_t           desc_q [$];
    int              free_q [$];                    // Checked packets awaiting release.

    port_wr_top DUT (
        .clk, .rst_n, .wr_sop, .wr_vld, .wr_eop, .wr_data, .free,
        .rd_bank, .rd_addr, .pause, .desc_vld, .desc, .rd_data
    );

    always #2 clk = ~clk;

    task automatic mismatch(input string sig, input int got, input int exp, input int cat);
        err_cnt[cat]++;
        $display("ERR %0t %s got %0h exp %0h", $time, sig, got, exp);
    endtask

    task automatic report_error(input string what, input int cat);
        err_cnt[cat]++;
        $display("ERROR %0t %s", $time, what);
    endtask

    function automatic int total_errors();
        return err_cnt[E_DESC] + err_cnt[E_PLACE] + err_cnt[E_DATA] + err_cnt[E_CTRL];
    endfunction

    task automatic print_counts();
        $display("Errors: desc %0d, placement %0d, data %0d, control %0d, total %0d",
                 err_cnt[E_DESC], err_cnt[E_PLACE], err_cnt[E_DATA], err_cnt[E_CTRL],
                 total_errors());
    endtask

    // Lowest numbered bank that still has room.
    function automatic int find_bank(input int len);
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (model_free[b] >= len) begin
                return b;
            end
        end
        return -1;
    endfunction

    task automatic gen_packets();
        pkt_word_u hdr;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_len[p]     = 2 + int'($unsigned($random(seed)) % (MAX_LEN - 1));
            hdr.hdr.length = 9'(pkt_len[p]);
            hdr.hdr.prio   = 3'($random(seed));
            hdr.hdr.dest   = 4'($random(seed));
            pkt_data[p][0] = hdr.raw;
            word_gap[p][0] = 1'b0;
            for (int i = 1; i < MAX_LEN; i++) begin
                pkt_data[p][i] = 16'($random(seed));
                word_gap[p][i] = ($random(seed) & 7) == 0;  // Makes the frontend stall.
            end
            pkt_gap[p]  = int'($unsigned($random(seed)) % 4);
            free_dly[p] = int'($unsigned($random(seed)) % 256);  // Slow enough to fill banks.
        end
    endtask

    task automatic send_packet(input int p);
        @(negedge clk);
        wr_sop = 1'b1;
        @(negedge clk);
        wr_sop = 1'b0;
        for (int i = 0; i < pkt_len[p]; i++) begin
            if (word_gap[p][i]) begin
                @(negedge clk);
            end
            while (pause) begin
                @(negedge clk);  // Held by the frontend.
            end
            wr_vld      = 1'b1;
            wr_data.raw = pkt_data[p][i];
            @(negedge clk);
            wr_vld = 1'b0;
        end
        wr_eop = 1'b1;
        @(negedge clk);
        wr_eop = 1'b0;
    endtask

    task automatic check_quiet(input string phase);
        if (pause !== 1'b0) begin
            mismatch({"pause ", phase}, int'(pause), 0, E_CTRL);
        end
        if (desc_vld !== 1'b0) begin
            mismatch({"desc_vld ", phase}, int'(desc_vld), 0, E_CTRL);
        end
    endtask

    // Bank model, free strobes and descriptor capture.
    always @(negedge clk) begin
        int b;
        int p;
        if (rst_n) begin
            if (DUT.grant.suc) begin  // Decided at the edge just gone.
                b = (grant_idx < NUM_PKTS) ? find_bank(pkt_len[grant_idx]) : -1;
                if (b < 0) begin
                    report_error("grant issued while no bank had room", E_PLACE);
                end else begin
                    exp_bank[grant_idx]  = b;
                    exp_start[grant_idx] = model_wp[b];
                    model_free[b]       -= pkt_len[grant_idx];
                    model_wp[b]          = (model_wp[b] + pkt_len[grant_idx]) % BANK_DEPTH;
                end
                grant_idx++;
            end
            if (free.vld) begin
                model_free[free.bank] += int'(free.length);  // Counted after that grant.
            end
            free = '0;
            if (free_wait > 0) begin
                free_wait--;
            end else if (free_q.size() != 0) begin
                p           = free_q.pop_front();
                free.vld    = 1'b1;
                free.bank   = 2'(exp_bank[p]);
                free.length = 9'(pkt_len[p]);
                free_wait   = free_dly[p];
            end
            if (desc_vld) begin
                desc_q.push_back(desc);
            end
        end
    end

    // Descriptor check and bank read back, in send order.
    initial begin
        desc_t d;
        int    idx;
        idx = 0;
        forever begin
            while (desc_q.size() == 0) begin
                @(posedge clk);
            end
            d = desc_q.pop_front();
            if (idx >= NUM_PKTS) begin
                report_error("descriptor with no packet sent for it", E_DESC);
            end else begin
                if (int'(d.dest) != int'(pkt_data[idx][0][3:0])) begin
                    mismatch("desc.dest", int'(d.dest), int'(pkt_data[idx][0][3:0]), E_DESC);
                end
                if (int'(d.length) != pkt_len[idx]) begin
                    mismatch("desc.length", int'(d.length), pkt_len[idx], E_DESC);
                end
                if (int'(d.bank) != exp_bank[idx]) begin
                    mismatch("desc.bank", int'(d.bank), exp_bank[idx], E_PLACE);
                end
                if (int'(d.start) != exp_start[idx]) begin
                    mismatch("desc.start", int'(d.start), exp_start[idx], E_PLACE);
                end
                @(negedge clk);
                for (int i = 0; i < pkt_len[idx]; i++) begin
                    rd_bank = d.bank;
                    rd_addr = 8'((int'(d.start) + i) % BANK_DEPTH);
                    @(negedge clk);  // Registered read.
                    if (rd_data !== pkt_data[idx][i]) begin
                        mismatch($sformatf("rd_data[%0d]", i), int'(rd_data),
                                 int'(pkt_data[idx][i]), E_DATA);
                    end
                end
                @(posedge clk);
                free_q.push_back(idx);
            end
            idx++;
            n_checked++;
        end
    end

    initial begin
        repeat (NUM_PKTS * CYC_PER_PKT) @(posedge clk);
        $display("Watchdog expired with %0d of %0d packets checked", n_checked, NUM_PKTS);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        wr_sop      = 1'b0;
        wr_vld      = 1'b0;
        wr_eop      = 1'b0;
        wr_data.raw = '0;
        free        = '0;
        rd_bank     = '0;
        rd_addr     = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            model_free[b] = BANK_DEPTH;
            model_wp[b]   = 0;
        end
        gen_packets();
        repeat (10) begin
            @(negedge clk);
            check_quiet("in reset");
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_quiet("after reset");
        end
        for (int p = 0; p < NUM_PKTS; p++) begin
            repeat (pkt_gap[p]) @(negedge clk);
            send_packet(p);
        end
        while (n_checked < NUM_PKTS) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);  // Catches stray descriptors.
        print_counts();
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/switch_pkg.sv
src/sram_bank.sv
src/sram_matcher.sv
src/sram_bank_writer.sv
src/port_wr_frontend.sv
src/port_wr_top.sv
verification/port_wr_asserts.sv
verification/port_wr_tb.sv
